//--- common/mul_pkg.sv
package mul_pkg;

    // operand and product widths
    localparam int unsigned operand_width = 8;
    localparam int unsigned product_width = 2 * operand_width;

    // two rows, the odd one shifted up by one
    localparam int unsigned pair_sum_width = operand_width + 2;

    // four rows, two pair sums with the upper one shifted by two
    localparam int unsigned quad_sum_width = operand_width + 4;

    typedef logic [operand_width-1:0] operand_t;

    typedef logic [product_width-1:0] product_t;

    typedef logic [pair_sum_width-1:0] pair_sum_t;

    typedef logic [quad_sum_width-1:0] quad_sum_t;

endpackage

//--- hw/kogge_stone/kogge_stone_adder.sv
`timescale 1ns/1ps

module kogge_stone_adder #(
    parameter int width = 8
) (
    input  logic [width-1:0] in1,
    input  logic [width-1:0] in2,
    output logic [width-1:0] sum,
    output logic             cout
);

    // number of prefix levels, zero for a 1-bit adder
    localparam int levels = (width > 1) ? $clog2(width) : 0;

    // group generate / propagate after each level, index 0 is bitwise
    logic [width-1:0] g_lvl [0:levels];
    logic [width-1:0] p_lvl [0:levels];

    // carry into each bit position
    logic [width-1:0] carry;

    // bitwise generate and propagate
    assign g_lvl[0] = in1 & in2;
    assign p_lvl[0] = in1 ^ in2;

    genvar lvl;
    genvar i;

    generate
        for (lvl = 0; lvl < levels; lvl++) begin : g_level
            localparam int span = 1 << lvl;

            for (i = 0; i < width; i++) begin : g_bit
                if (i < span) begin : g_pass
                    // group already reaches bit 0
                    assign g_lvl[lvl+1][i] = g_lvl[lvl][i];
                    assign p_lvl[lvl+1][i] = p_lvl[lvl][i];
                end else if (i < 2 * span) begin : g_gray
                    // lower group ends at bit 0, only generate matters
                    assign g_lvl[lvl+1][i] = g_lvl[lvl][i] |
                                             (p_lvl[lvl][i] & g_lvl[lvl][i-span]);
                    assign p_lvl[lvl+1][i] = 1'b0; // never read past this level
                end else begin : g_black
                    assign g_lvl[lvl+1][i] = g_lvl[lvl][i] |
                                             (p_lvl[lvl][i] & g_lvl[lvl][i-span]);
                    assign p_lvl[lvl+1][i] = p_lvl[lvl][i] & p_lvl[lvl][i-span];
                end
            end
        end
    endgenerate

    // carry-in is zero, so bit 0 sees no carry
    assign carry[0] = 1'b0;

    generate
        for (i = 1; i < width; i++) begin : g_carry
            assign carry[i] = g_lvl[levels][i-1]; // group [i-1:0]
        end
    endgenerate

    assign sum  = p_lvl[0] ^ carry;
    assign cout = g_lvl[levels][width-1];

endmodule

//--- hw/pp_pair_stage.sv
`timescale 1ns/1ps

module pp_pair_stage (
    input  mul_pkg::operand_t  a,
    input  mul_pkg::operand_t  b,
    output mul_pkg::pair_sum_t pair_sum_0,
    output mul_pkg::pair_sum_t pair_sum_1,
    output mul_pkg::pair_sum_t pair_sum_2,
    output mul_pkg::pair_sum_t pair_sum_3
);

    // one partial-product row per bit of a
    mul_pkg::operand_t rows [0:mul_pkg::operand_width-1];

    // adder operands and results, one per row pair
    mul_pkg::operand_t add_in1 [0:mul_pkg::operand_width/2-1];
    mul_pkg::operand_t add_in2 [0:mul_pkg::operand_width/2-1];
    mul_pkg::operand_t add_sum [0:mul_pkg::operand_width/2-1];
    logic              add_cout [0:mul_pkg::operand_width/2-1];

    // assembled pair sums
    mul_pkg::pair_sum_t pair_sum [0:mul_pkg::operand_width/2-1];

    genvar k;

    generate
        for (k = 0; k < mul_pkg::operand_width; k++) begin : g_row
            assign rows[k] = a[k] ? b : '0; // b gated by bit k of a
        end
    endgenerate

    generate
        for (k = 0; k < mul_pkg::operand_width / 2; k++) begin : g_pair
            // even row drops its lsb, odd row sits one bit higher
            assign add_in1[k] = {1'b0, rows[2*k][mul_pkg::operand_width-1:1]};
            assign add_in2[k] = rows[2*k+1];

            kogge_stone_adder #(
                .width (mul_pkg::operand_width)
            ) u_adder (
                .in1  (add_in1[k]),
                .in2  (add_in2[k]),
                .sum  (add_sum[k]),
                .cout (add_cout[k])
            );

            assign pair_sum[k] = {add_cout[k], add_sum[k], rows[2*k][0]};
        end
    endgenerate

    assign pair_sum_0 = pair_sum[0];
    assign pair_sum_1 = pair_sum[1];
    assign pair_sum_2 = pair_sum[2];
    assign pair_sum_3 = pair_sum[3];

endmodule

//--- hw/pp_quad_stage.sv
`timescale 1ns/1ps

module pp_quad_stage (
    input  mul_pkg::pair_sum_t pair_sum_0,
    input  mul_pkg::pair_sum_t pair_sum_1,
    input  mul_pkg::pair_sum_t pair_sum_2,
    input  mul_pkg::pair_sum_t pair_sum_3,
    output mul_pkg::quad_sum_t quad_sum_0,
    output mul_pkg::quad_sum_t quad_sum_1
);

    // lower and higher pair sum of each quad
    mul_pkg::pair_sum_t lower [0:1];
    mul_pkg::pair_sum_t higher [0:1];

    mul_pkg::pair_sum_t add_in1 [0:1];
    mul_pkg::pair_sum_t add_sum [0:1];

    mul_pkg::quad_sum_t quad_sum [0:1];

    assign lower[0]  = pair_sum_0;
    assign higher[0] = pair_sum_1;
    assign lower[1]  = pair_sum_2;
    assign higher[1] = pair_sum_3;

    genvar q;

    generate
        for (q = 0; q < 2; q++) begin : g_quad
            // higher pair weighs four times the lower one
            assign add_in1[q] = {2'b00, lower[q][mul_pkg::pair_sum_width-1:2]};

            // carry out cannot be set for 8-bit operands
            kogge_stone_adder #(
                .width (mul_pkg::pair_sum_width)
            ) u_adder (
                .in1  (add_in1[q]),
                .in2  (higher[q]),
                .sum  (add_sum[q]),
                .cout ()
            );

            assign quad_sum[q] = {add_sum[q], lower[q][1:0]};
        end
    endgenerate

    assign quad_sum_0 = quad_sum[0];
    assign quad_sum_1 = quad_sum[1];

endmodule

//--- hw/multiplier_8x8.sv
`timescale 1ns/1ps

module multiplier_8x8 (
    input  mul_pkg::operand_t a,
    input  mul_pkg::operand_t b,
    output mul_pkg::product_t product
);

    mul_pkg::pair_sum_t pair_sum_0;
    mul_pkg::pair_sum_t pair_sum_1;
    mul_pkg::pair_sum_t pair_sum_2;
    mul_pkg::pair_sum_t pair_sum_3;

    mul_pkg::quad_sum_t quad_sum_0;
    mul_pkg::quad_sum_t quad_sum_1;

    mul_pkg::quad_sum_t final_in1;
    mul_pkg::quad_sum_t final_sum;

    pp_pair_stage u_pair (
        .a          (a),
        .b          (b),
        .pair_sum_0 (pair_sum_0),
        .pair_sum_1 (pair_sum_1),
        .pair_sum_2 (pair_sum_2),
        .pair_sum_3 (pair_sum_3)
    );

    pp_quad_stage u_quad (
        .pair_sum_0 (pair_sum_0),
        .pair_sum_1 (pair_sum_1),
        .pair_sum_2 (pair_sum_2),
        .pair_sum_3 (pair_sum_3),
        .quad_sum_0 (quad_sum_0),
        .quad_sum_1 (quad_sum_1)
    );

    // upper quad sits sixteen times higher
    assign final_in1 = {4'b0000, quad_sum_0[mul_pkg::quad_sum_width-1:4]};

    // carry out cannot be set for 8-bit operands
    kogge_stone_adder #(
        .width (mul_pkg::quad_sum_width)
    ) u_final (
        .in1  (final_in1),
        .in2  (quad_sum_1),
        .sum  (final_sum),
        .cout ()
    );

    assign product = {final_sum, quad_sum_0[3:0]};

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real period = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2.0);
            clk = ~clk;
        end
    end

endmodule

//--- dv/multiplier_8x8_tb.sv
`timescale 1ns/1ps

module multiplier_8x8_tb;

    localparam int reset_cycles  = 5;
    localparam int total_vectors = 3 + 512 + 3 + 64 + 2000 + 400;
    localparam int max_cycles    = total_vectors + reset_cycles + 50;

    logic              clk;
    logic              reset;
    mul_pkg::operand_t a;
    mul_pkg::operand_t b;
    mul_pkg::product_t product;

    // per-behavior flags, set with the vector they belong to
    logic              swap_phase;
    logic              walk_active;
    mul_pkg::product_t walk_expected;

    logic [15:0] lfsr_state;
    int          error_count;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    tb_clock #(.period (4.0)) u_clock (.clk (clk));

    multiplier_8x8 dut (
        .a       (a),
        .b       (b),
        .product (product)
    );

    // product must equal a times b on every vector
    assert property (@(posedge clk) disable iff (reset)
        product == mul_pkg::product_t'(a) * mul_pkg::product_t'(b))
    else begin
        error_count++;
        $display("** Error at %0t: %0d * %0d expected %0d, got %0d", $time, a, b,
                 mul_pkg::product_t'(a) * mul_pkg::product_t'(b), product);
    end

    assert property (@(posedge clk) disable iff (reset)
        (a == 0 || b == 0) |-> product == 0)
    else begin
        error_count++;
        $display("** Error at %0t: zero operand %0d * %0d gave %0d", $time, a, b, product);
    end

    assert property (@(posedge clk) disable iff (reset)
        (a == 1) |-> product == mul_pkg::product_t'(b))
    else begin
        error_count++;
        $display("** Error at %0t: 1 * %0d gave %0d", $time, b, product);
    end

    assert property (@(posedge clk) disable iff (reset)
        (b == 1) |-> product == mul_pkg::product_t'(a))
    else begin
        error_count++;
        $display("** Error at %0t: %0d * 1 gave %0d", $time, a, product);
    end

    assert property (@(posedge clk) disable iff (reset)
        (a == 8'hff && b == 8'hff) |-> product == 16'd65025)
    else begin
        error_count++;
        $display("** Error at %0t: 255 * 255 gave %0d", $time, product);
    end

    assert property (@(posedge clk) disable iff (reset)
        walk_active |-> product == walk_expected)
    else begin
        error_count++;
        $display("** Error at %0t: walking bits %0d * %0d expected %0d, got %0d",
                 $time, a, b, walk_expected, product);
    end

    // second vector of a swapped pair must repeat the first product
    assert property (@(posedge clk) disable iff (reset)
        swap_phase |-> product == $past(product))
    else begin
        error_count++;
        $display("** Error at %0t: %0d * %0d gave %0d, swapped order gave %0d",
                 $time, a, b, product, $past(product));
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_byte(output mul_pkg::operand_t value);
        value = '0;
        for (int n = 0; n < 8; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[6:0], lfsr_state[0]}; // one step per bit
        end
    endtask

    task automatic apply_operands(input mul_pkg::operand_t a_val, input mul_pkg::operand_t b_val);
        @(posedge clk);
        #1;
        a = a_val;
        b = b_val;
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        @(posedge clk); // last vector checked here
        #1;
        swap_phase  = 1'b0;
        walk_active = 1'b0;
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
    endtask

    task automatic zero_operands();
        start_test();
        apply_operands(8'd0, 8'd173);
        apply_operands(8'd91, 8'd0);
        apply_operands(8'd0, 8'd0);
        finish_test("zero operands");
    endtask

    task automatic identity_sweep();
        start_test();
        for (int v = 0; v < 256; v++)
            apply_operands(8'd1, mul_pkg::operand_t'(v));
        for (int v = 0; v < 256; v++)
            apply_operands(mul_pkg::operand_t'(v), 8'd1);
        finish_test("identity");
    endtask

    task automatic extreme_values();
        start_test();
        apply_operands(8'd255, 8'd255);
        apply_operands(8'd255, 8'd1);
        apply_operands(8'd128, 8'd128);
        finish_test("extremes");
    endtask

    task automatic walking_bits();
        start_test();
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                apply_operands(mul_pkg::operand_t'(1 << i), mul_pkg::operand_t'(1 << j));
                walk_active   = 1'b1;
                walk_expected = mul_pkg::product_t'(1) << (i + j);
            end
        end
        finish_test("walking bits");
    endtask

    task automatic random_pairs();
        mul_pkg::operand_t x;
        mul_pkg::operand_t y;
        start_test();
        for (int n = 0; n < 2000; n++) begin
            random_byte(x);
            random_byte(y);
            apply_operands(x, y);
        end
        finish_test("random pairs");
    endtask

    task automatic commutativity();
        mul_pkg::operand_t x;
        mul_pkg::operand_t y;
        start_test();
        for (int n = 0; n < 200; n++) begin
            random_byte(x);
            random_byte(y);
            apply_operands(x, y);
            swap_phase = 1'b0;
            apply_operands(y, x);
            swap_phase = 1'b1;
        end
        finish_test("commutativity");
    endtask

    initial begin
        reset         = 1'b1;
        a             = '0;
        b             = '0;
        swap_phase    = 1'b0;
        walk_active   = 1'b0;
        walk_expected = '0;
        lfsr_state    = 16'd26;
        error_count   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        cycle_count   = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        zero_operands();
        identity_sweep();
        extreme_values();
        walking_bits();
        random_pairs();
        commutativity();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- multiplier_8x8.f
common/mul_pkg.sv
hw/kogge_stone/kogge_stone_adder.sv
hw/pp_pair_stage.sv
hw/pp_quad_stage.sv
hw/multiplier_8x8.sv
dv/tb_clock.sv
dv/multiplier_8x8_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module multiplier_8x8_tb \
    -f multiplier_8x8.f \
    -o sim_multiplier_8x8

output=$(./obj_dir/sim_multiplier_8x8)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
